//--- Makefile
VERILATOR ?= verilator
TOP       := tb_cam_top
FILELIST  := files.f
FLAGS     := --timing --assert
BUILD_DIR := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- cam_csr.sv
// Camera register bank
`timescale 1ns/1ps

module cam_csr (
  input  logic              pixel_clk_i,
  input  logic              rst_n_i,
  input  cam_pkg::csr_req_t csr_req_i,
  output cam_pkg::csr_rsp_t csr_rsp_o,
  input  cam_pkg::stats_t   stats_i,
  output logic              rx_en_o,
  output logic              tx_en_o,
  output logic              test_pattern_en_o,
  output logic              test_pattern_type_o
);
  import cam_pkg::*;

  logic        req;                            // Cycle and strobe both up
  logic        stage_q;                        // First edge of access taken
  logic        fire;                           // Second edge, ack and write
  logic        ack_q;
  logic        hold_q;                         // Waiting for stb to drop
  logic [3:0]  ctrl_q;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;

  assign req  = csr_req_i.cyc & csr_req_i.stb;
  assign fire = stage_q & req;                 // Dropped request gets no ack

  // ********************************************************************
  // Access sequence and control register
  // ********************************************************************
  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_q <= 1'b0;
      ack_q   <= 1'b0;
      hold_q  <= 1'b0;
      ctrl_q  <= '0;
    end else begin
      // New access only once the previous one has fully closed
      stage_q <= req & ~stage_q & ~ack_q & ~hold_q;
      ack_q   <= fire;
      hold_q  <= (hold_q | ack_q) & req;      // Released when stb drops
      if (fire && csr_req_i.we && (csr_req_i.adr == REG_CTRL)) begin
        ctrl_q <= csr_req_i.dat[3:0];          // Upper bits ignored
      end
    end
  end

  // Read decode
  always_comb begin
    rdata_d = '0;                              // Unmapped reads as zero
    case (csr_req_i.adr)
      REG_CTRL:   rdata_d = {28'd0, ctrl_q};
      REG_SIZE:   rdata_d = {stats_i.rows, stats_i.cols};
      REG_FRAMES: rdata_d = stats_i.frames;
      REG_AVG0:   rdata_d = 32'(stats_i.avg[0]);
      REG_AVG1:   rdata_d = 32'(stats_i.avg[1]);
      REG_AVG2:   rdata_d = 32'(stats_i.avg[2]);
      REG_AVG3:   rdata_d = 32'(stats_i.avg[3]);
      REG_ID:     rdata_d = CSR_ID;
      default:    rdata_d = '0;
    endcase
  end

  always_ff @(posedge pixel_clk_i) begin
    if (fire) begin
      rdata_q <= rdata_d;                      // Lines up with ack
    end
  end

  assign csr_rsp_o.ack = ack_q;
  assign csr_rsp_o.dat = rdata_q;

  // Control levels out to the image path
  assign rx_en_o             = ctrl_q[CTRL_RX_EN];
  assign tx_en_o             = ctrl_q[CTRL_TX_EN];
  assign test_pattern_en_o   = ctrl_q[CTRL_TP_EN];
  assign test_pattern_type_o = ctrl_q[CTRL_TP_TYPE];

  // Single cycle acknowledge
  a_ack_single : assert property (@(posedge pixel_clk_i) disable iff (!rst_n_i)
    ack_q |=> !ack_q)
    else $error("cam_csr: ack held for two cycles");

  // Every ack answers a request seen the cycle before
  a_ack_req : assert property (@(posedge pixel_clk_i) disable iff (!rst_n_i)
    ack_q |-> $past(req))
    else $error("cam_csr: ack without a request");

endmodule

//--- cam_pkg.sv
// Camera image path definitions
package cam_pkg;

  // ********************************************************************
  // Video stream
  // ********************************************************************
  localparam int PIXEL_BITS = 10;               // RAW10 sample

  typedef logic [PIXEL_BITS-1:0] pixel_t;

  typedef struct packed {
    logic   fv;                                 // Frame valid
    logic   lv;                                 // Line valid, inside fv only
    pixel_t data;
  } video_t;

  // ********************************************************************
  // Register bus
  // ********************************************************************
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [7:0]  adr;                           // Byte address
    logic [31:0] dat;                           // Write data
  } csr_req_t;

  typedef struct packed {
    logic        ack;                           // One cycle per access
    logic [31:0] dat;                           // Read data, valid with ack
  } csr_rsp_t;

  // Register offsets
  localparam logic [7:0] REG_CTRL   = 8'h00;
  localparam logic [7:0] REG_SIZE   = 8'h04;    // Rows high, cols low
  localparam logic [7:0] REG_FRAMES = 8'h08;
  localparam logic [7:0] REG_AVG0   = 8'h10;
  localparam logic [7:0] REG_AVG1   = 8'h14;
  localparam logic [7:0] REG_AVG2   = 8'h18;
  localparam logic [7:0] REG_AVG3   = 8'h1C;
  localparam logic [7:0] REG_ID     = 8'h20;

  // Control bit positions
  localparam int CTRL_RX_EN   = 0;
  localparam int CTRL_TX_EN   = 1;
  localparam int CTRL_TP_EN   = 2;
  localparam int CTRL_TP_TYPE = 3;              // 0 bars, 1 ramp

  localparam logic [31:0] CSR_ID = 32'hFEED_F00D;

  // Colour bars, eight steps from 0 to 1022
  localparam int NUM_BARS = 8;
  localparam int BAR_STEP = 146;

  typedef struct packed {
    logic [15:0]  cols;                         // Last line length
    logic [15:0]  rows;                         // Lines in frame
    logic [31:0]  frames;                       // Counted frames
    pixel_t [3:0] avg;                          // Bayer channel averages
  } stats_t;

endpackage

//--- cam_top.sv
// Camera image path top level
`timescale 1ns/1ps

module cam_top #(
  parameter int NUM_COLS = 32,                 // Active pixels per line
  parameter int NUM_ROWS = 16,                 // Active lines per frame
  parameter int H_BLANK  = 8,
  parameter int V_BLANK  = 20,
  parameter int FV_EXT   = 10                  // Transmit fv stretch
) (
  input  logic              pixel_clk_i,
  input  logic              rst_n_i,
  input  cam_pkg::csr_req_t csr_req_i,
  output cam_pkg::csr_rsp_t csr_rsp_o,
  input  cam_pkg::video_t   cam_i,
  output cam_pkg::video_t   tx_o,
  output logic              irq_frame_o
);
  import cam_pkg::*;

  stats_t stats;
  video_t pattern;
  logic   rx_en;
  logic   tx_en;
  logic   test_pattern_en;
  logic   test_pattern_type;
  logic   pattern_en;

  // Pattern runs only when it is also being sent
  assign pattern_en = tx_en & test_pattern_en;

  // ********************************************************************
  // Register bank
  // ********************************************************************
  cam_csr i_cam_csr (
    .pixel_clk_i        (pixel_clk_i      ),
    .rst_n_i            (rst_n_i          ),
    .csr_req_i          (csr_req_i        ),
    .csr_rsp_o          (csr_rsp_o        ),
    .stats_i            (stats            ),
    .rx_en_o            (rx_en            ),
    .tx_en_o            (tx_en            ),
    .test_pattern_en_o  (test_pattern_en  ),
    .test_pattern_type_o(test_pattern_type)
  );

  // ********************************************************************
  // Receive statistics
  // ********************************************************************
  image_stats #(
    .NUM_COLS(NUM_COLS),
    .NUM_ROWS(NUM_ROWS)
  ) i_image_stats (
    .pixel_clk_i (pixel_clk_i),
    .rst_n_i     (rst_n_i    ),
    .rx_en_i     (rx_en      ),
    .cam_i       (cam_i      ),
    .stats_o     (stats      ),
    .frame_done_o(irq_frame_o)                 // Frame interrupt
  );

  // ********************************************************************
  // Transmit path
  // ********************************************************************
  pattern_gen #(
    .NUM_COLS(NUM_COLS),
    .NUM_ROWS(NUM_ROWS),
    .H_BLANK (H_BLANK ),
    .V_BLANK (V_BLANK )
  ) i_pattern_gen (
    .pixel_clk_i   (pixel_clk_i      ),
    .rst_n_i       (rst_n_i          ),
    .enable_i      (pattern_en       ),
    .pattern_type_i(test_pattern_type),
    .video_o       (pattern          )
  );

  tx_source_sel #(
    .FV_EXT(FV_EXT)
  ) i_tx_source_sel (
    .pixel_clk_i  (pixel_clk_i    ),
    .rst_n_i      (rst_n_i        ),
    .tx_en_i      (tx_en          ),
    .pattern_sel_i(test_pattern_en),
    .cam_i        (cam_i          ),
    .pattern_i    (pattern        ),
    .tx_o         (tx_o           )
  );

endmodule

//--- files.f
+incdir+.
cam_pkg.sv
cam_csr.sv
image_stats.sv
pattern_gen.sv
tx_source_sel.sv
cam_top.sv
tb_cam_top.sv

//--- image_stats.sv
// Bayer frame statistics
`timescale 1ns/1ps

module image_stats #(
  parameter int NUM_COLS = 32,                 // Power of two
  parameter int NUM_ROWS = 16                  // Power of two
) (
  input  logic              pixel_clk_i,
  input  logic              rst_n_i,
  input  logic              rx_en_i,
  input  cam_pkg::video_t   cam_i,
  output cam_pkg::stats_t   stats_o,
  output logic              frame_done_o
);
  import cam_pkg::*;

  // Quarter of the frame lands in each channel
  localparam int AVG_SHIFT = $clog2((NUM_COLS * NUM_ROWS) / 4);
  localparam int ACC_BITS  = PIXEL_BITS + $clog2(NUM_COLS * NUM_ROWS);

  logic                     fv_q;
  logic                     lv_q;
  logic                     fv_rise;
  logic                     fv_fall;
  logic                     lv_fall;
  logic                     active_q;          // Frame started with rx_en
  logic                     frame_on;
  logic                     pix_en;
  logic [15:0]              col_q;             // Pixel index in line
  logic [15:0]              row_q;             // Line index in frame
  logic [15:0]              line_len_q;
  logic [15:0]              line_len_nxt;
  logic [15:0]              rows_nxt;
  logic [1:0]               chan;
  logic [3:0][ACC_BITS-1:0] acc_q;

  assign fv_rise = cam_i.fv & ~fv_q;
  assign fv_fall = fv_q & ~cam_i.fv;
  assign lv_fall = lv_q & ~cam_i.lv;

  // A line may close in the same cycle as the frame
  assign line_len_nxt = lv_fall ? col_q : line_len_q;
  assign rows_nxt     = row_q + 16'(lv_fall);

  assign frame_on = fv_rise ? rx_en_i : active_q;
  assign pix_en   = cam_i.lv & rx_en_i & frame_on;
  assign chan     = {row_q[0], col_q[0]};      // Row bit then column bit

  // ********************************************************************
  // Position tracking and frame capture
  // ********************************************************************
  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fv_q         <= 1'b0;
      lv_q         <= 1'b0;
      active_q     <= 1'b0;
      col_q        <= '0;
      row_q        <= '0;
      line_len_q   <= '0;
      stats_o      <= '0;
      frame_done_o <= 1'b0;
    end else begin
      fv_q         <= cam_i.fv;
      lv_q         <= cam_i.lv;
      frame_done_o <= 1'b0;
      if (fv_rise) begin
        active_q <= rx_en_i;                   // Sampled once per frame
      end
      col_q <= cam_i.lv ? col_q + 16'd1 : '0;
      if (lv_fall) begin
        line_len_q <= col_q;
      end
      if (!cam_i.fv) begin
        row_q <= '0;
      end else if (lv_fall) begin
        row_q <= row_q + 16'd1;
      end
      // Publish one cycle after fv drops
      if (fv_fall && active_q) begin
        stats_o.cols   <= line_len_nxt;
        stats_o.rows   <= rows_nxt;
        stats_o.frames <= stats_o.frames + 32'd1;
        for (int i = 0; i < 4; i++) begin
          stats_o.avg[i] <= PIXEL_BITS'(acc_q[i] >> AVG_SHIFT);
        end
        frame_done_o   <= 1'b1;
        active_q       <= 1'b0;
      end
    end
  end

  // Channel sums, cleared whenever no frame is running
  always_ff @(posedge pixel_clk_i) begin
    if (!cam_i.fv) begin
      acc_q <= '0;
    end else if (pix_en) begin
      acc_q[chan] <= acc_q[chan] + ACC_BITS'(cam_i.data);
    end
  end

  a_lv_in_fv : assert property (@(posedge pixel_clk_i) disable iff (!rst_n_i)
    cam_i.lv |-> cam_i.fv)
    else $error("image_stats: line valid outside frame valid");

  // Averages are shifts, so sizes must be powers of two
  a_pow2 : assert property (@(posedge pixel_clk_i)
    ((NUM_COLS & (NUM_COLS - 1)) == 0) && ((NUM_ROWS & (NUM_ROWS - 1)) == 0))
    else $error("image_stats: NUM_COLS and NUM_ROWS must be powers of two");

endmodule

//--- pattern_gen.sv
// Test pattern generator
`timescale 1ns/1ps

module pattern_gen #(
  parameter int NUM_COLS = 32,                 // Multiple of NUM_BARS
  parameter int NUM_ROWS = 16,
  parameter int H_BLANK  = 8,                  // Idle cycles after a line
  parameter int V_BLANK  = 20                  // Idle cycles between frames
) (
  input  logic            pixel_clk_i,
  input  logic            rst_n_i,
  input  logic            enable_i,
  input  logic            pattern_type_i,      // 0 bars, 1 ramp
  output cam_pkg::video_t video_o
);
  import cam_pkg::*;

  localparam int COL_BITS  = $clog2(NUM_COLS);
  localparam int ROW_BITS  = $clog2(NUM_ROWS);
  localparam int BLK_MAX   = (H_BLANK > V_BLANK) ? H_BLANK : V_BLANK;
  localparam int BLK_BITS  = $clog2(BLK_MAX + 1);
  localparam int BAR_SHIFT = $clog2(NUM_COLS / NUM_BARS);

  typedef enum logic [1:0] {ST_VBLANK, ST_ACTIVE, ST_HBLANK} state_t;

  state_t                          state_q;
  logic [COL_BITS-1:0]             col_q;
  logic [ROW_BITS-1:0]             row_q;
  logic [BLK_BITS-1:0]             blk_q;      // Shared by both blankings
  logic [COL_BITS-BAR_SHIFT-1:0]   bar_idx;
  pixel_t                          bar_data;
  pixel_t                          ramp_data;

  // ********************************************************************
  // Line and frame sequencing
  // ********************************************************************
  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_VBLANK;
      col_q   <= '0;
      row_q   <= '0;
      blk_q   <= '0;
    end else if (!enable_i) begin
      state_q <= ST_VBLANK;                    // Park at start of blanking
      col_q   <= '0;
      row_q   <= '0;
      blk_q   <= '0;
    end else begin
      case (state_q)
        ST_VBLANK: begin
          if (blk_q == BLK_BITS'(V_BLANK - 1)) begin
            blk_q   <= '0;
            state_q <= ST_ACTIVE;
          end else begin
            blk_q <= blk_q + 1'b1;
          end
        end
        ST_ACTIVE: begin
          if (col_q == COL_BITS'(NUM_COLS - 1)) begin
            col_q   <= '0;
            state_q <= ST_HBLANK;
          end else begin
            col_q <= col_q + 1'b1;
          end
        end
        ST_HBLANK: begin
          if (blk_q == BLK_BITS'(H_BLANK - 1)) begin
            blk_q <= '0;
            if (row_q == ROW_BITS'(NUM_ROWS - 1)) begin
              row_q   <= '0;
              state_q <= ST_VBLANK;            // fv drops after last blank
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= ST_ACTIVE;
            end
          end else begin
            blk_q <= blk_q + 1'b1;
          end
        end
        default: state_q <= ST_VBLANK;
      endcase
    end
  end

  // Bar index is the top bits of the column
  assign bar_idx   = col_q[COL_BITS-1:BAR_SHIFT];
  assign bar_data  = PIXEL_BITS'(bar_idx * BAR_STEP);
  assign ramp_data = PIXEL_BITS'(col_q);

  assign video_o.fv   = (state_q != ST_VBLANK);
  assign video_o.lv   = (state_q == ST_ACTIVE);
  assign video_o.data = video_o.lv ? (pattern_type_i ? ramp_data : bar_data) : '0;

  a_lv_in_fv : assert property (@(posedge pixel_clk_i) disable iff (!rst_n_i)
    video_o.lv |-> video_o.fv)
    else $error("pattern_gen: line valid outside frame valid");

endmodule

//--- tb_cam_tasks.svh
// Testbench bus and video helpers
`ifndef TB_CAM_TASKS_SVH
`define TB_CAM_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
task automatic rand_pixel(output pixel_t value);
  value = '0;
  for (int i = 0; i < PIXEL_BITS; i++) begin
    lfsr_q = lfsr_step(lfsr_q);
    value  = {value[PIXEL_BITS-2:0], lfsr_q[0]};
  end
endtask

// Pattern reference, bars by division of the column
function automatic logic [31:0] expected_pixel(input logic ptype, input int col);
  if (ptype) begin
    return col;                                // Ramp
  end
  return (col / (NUM_COLS / NUM_BARS)) * BAR_STEP;
endfunction

task automatic expect_value(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
  assert (got == exp) else begin
    errors++;
    $display("ERROR %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
  end
endtask

// ********************************************************************
// Register bus
// ********************************************************************
task automatic bus_access(input logic we, input logic [7:0] adr,
                          input logic [31:0] wdat, output logic [31:0] rdat);
  int waited;
  waited = 0;
  rdat   = '0;
  @(posedge clk);
  csr_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
  do begin                                     // Hold strobe until ack
    @(posedge clk);
    waited++;
  end while (!csr_rsp.ack && waited < ACK_TIMEOUT);
  if (csr_rsp.ack) begin
    rdat = csr_rsp.dat;                        // Valid in the ack cycle
  end else begin
    errors++;
    $display("Bus access to address %02h was never acknowledged", adr);
  end
  csr_req <= '0;
endtask

task automatic bus_write(input logic [7:0] adr, input logic [31:0] wdat);
  logic [31:0] ignored;
  bus_access(1'b1, adr, wdat, ignored);
endtask

task automatic bus_read_check(input logic [7:0] adr, input logic [31:0] exp,
                              input string what);
  logic [31:0] rdat;
  bus_access(1'b0, adr, '0, rdat);
  expect_value(what, rdat, exp);
endtask

// Camera frame, one constant value per Bayer channel
task automatic send_frame(input pixel_t [3:0] chan_val);
  for (int r = 0; r < NUM_ROWS; r++) begin
    for (int c = 0; c < NUM_COLS + H_BLANK; c++) begin
      @(posedge clk);
      cam.fv   <= 1'b1;
      cam.lv   <= (c < NUM_COLS);
      cam.data <= (c < NUM_COLS) ? chan_val[{r[0], c[0]}] : '0;
    end
  end
  for (int b = 0; b < V_BLANK; b++) begin
    @(posedge clk);
    cam <= '0;
  end
endtask

`endif

//--- tb_cam_top.sv
// Camera image path testbench
`timescale 1ns/1ps

module tb_cam_top;
  import cam_pkg::*;

  localparam int CLK_PERIOD      = 10;
  localparam int NUM_COLS        = 32;         // DUT defaults
  localparam int NUM_ROWS        = 16;
  localparam int H_BLANK         = 8;
  localparam int V_BLANK         = 20;
  localparam int FV_EXT          = 10;
  localparam int FRAME_CYCLES    = NUM_ROWS * (NUM_COLS + H_BLANK) + V_BLANK;
  localparam int WATCHDOG_CYCLES = 20 * FRAME_CYCLES;
  localparam int ACK_TIMEOUT     = 16;

  logic        clk;
  logic        rst_n;
  csr_req_t    csr_req;
  csr_rsp_t    csr_rsp;
  video_t      cam;
  video_t      tx;
  logic        irq;
  logic [31:0] lfsr_q;
  int          errors;
  int          assert_errors = 0;
  int          tests_run;
  int          tests_failed;
  int          errs_at_start;
  int          irq_count;
  logic        cam_fv_d;                       // Registered copy of camera fv
  logic        tx_fv_d;
  int          stretch_cnt;
  int          last_stretch;
  int          stretch_seen;
  logic        pass_chk;                       // Passthrough compare armed
  logic        tx_off_chk;                     // Transmit must stay idle

  cam_top i_dut (
    .pixel_clk_i(clk    ),
    .rst_n_i    (rst_n  ),
    .csr_req_i  (csr_req),
    .csr_rsp_o  (csr_rsp),
    .cam_i      (cam    ),
    .tx_o       (tx     ),
    .irq_frame_o(irq    )
  );

  `include "tb_cam_tasks.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ********************************************************************
  // Monitors
  // ********************************************************************
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_count    <= 0;
      cam_fv_d     <= 1'b0;
      tx_fv_d      <= 1'b0;
      stretch_cnt  <= 0;
      last_stretch <= 0;
      stretch_seen <= 0;
    end else begin
      if (irq) irq_count <= irq_count + 1;
      cam_fv_d <= cam.fv;
      tx_fv_d  <= tx.fv;
      // tx fv cycles past the fall of the registered copy
      if (cam_fv_d) stretch_cnt <= 0;
      else if (tx.fv) stretch_cnt <= stretch_cnt + 1;
      if (tx_fv_d && !tx.fv) begin
        last_stretch <= stretch_cnt;
        stretch_seen <= stretch_seen + 1;
      end
    end
  end

  a_ack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    csr_rsp.ack |=> !csr_rsp.ack)
    else begin
      assert_errors++;
      $display("Bus ack stayed high for more than one cycle at %0t ns", $time);
    end

  a_irq_pulse : assert property (@(posedge clk) disable iff (!rst_n) irq |=> !irq)
    else begin
      assert_errors++;
      $display("Frame interrupt stayed high for more than one cycle at %0t ns", $time);
    end

  a_passthrough : assert property (@(posedge clk) disable iff (!rst_n)
    pass_chk |-> (tx.lv == $past(cam.lv)) && (tx.data == $past(cam.data)))
    else begin
      assert_errors++;
      $display("ERROR %0t ns: tx_o does not follow cam_i one cycle later", $time);
    end

  a_tx_off : assert property (@(posedge clk) disable iff (!rst_n)
    tx_off_chk |-> !tx.fv && !tx.lv)
    else begin
      assert_errors++;
      $display("ERROR %0t ns: tx_o active while transmit is disabled", $time);
    end

  // ********************************************************************
  // Test bookkeeping
  // ********************************************************************
  task automatic begin_test();
    errs_at_start = errors + assert_errors;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors + assert_errors != errs_at_start) begin
      tests_failed++;
      $display("Test %-16s failed", name);
    end else begin
      $display("Test %-16s ok", name);
    end
  endtask

  task automatic ctrl_round_trip(input logic [31:0] val);
    bus_write(REG_CTRL, val);
    bus_read_check(REG_CTRL, val & 32'hF, "CTRL readback");
  endtask

  // Line and frame geometry of one transmitted pattern frame
  task automatic check_pattern_frame(input logic ptype);
    int col;
    int lines;
    int waited;
    col    = 0;
    lines  = 0;
    waited = 0;
    do begin                                   // Let any running frame end
      @(posedge clk);
      waited++;
    end while (tx.fv && waited < FRAME_CYCLES);
    do begin
      @(posedge clk);
      waited++;
    end while (!tx.fv && waited < 2 * FRAME_CYCLES);
    while (tx.fv) begin
      if (tx.lv) begin
        expect_value("pattern data", 32'(tx.data), expected_pixel(ptype, col));
        col++;
      end else if (col != 0) begin
        expect_value("pattern line length", col, NUM_COLS);
        lines++;
        col = 0;
      end
      @(posedge clk);
    end
    expect_value("pattern lines per frame", lines, NUM_ROWS);
  endtask

  // ********************************************************************
  // Stimulus sequence
  // ********************************************************************
  initial begin
    pixel_t [3:0] chan_val;
    int           irq0;
    int           seen0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    csr_req      = '0;
    cam          = '0;
    lfsr_q       = 32'h855a;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    pass_chk     = 1'b0;
    tx_off_chk   = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    begin_test();
    expect_value("tx_o valid after reset", 32'({tx.fv, tx.lv}), 32'd0);
    expect_value("irq after reset", 32'(irq), 32'd0);
    bus_read_check(REG_CTRL, 32'd0, "CTRL after reset");
    bus_read_check(REG_ID, 32'hFEED_F00D, "ID");
    report_test("reset state");

    begin_test();
    ctrl_round_trip(32'h0000_0005);
    ctrl_round_trip(32'h0000_000A);
    ctrl_round_trip(32'hFFFF_FFF3);            // Upper bits dropped
    bus_read_check(8'h0C, 32'd0, "unmapped read");
    bus_write(REG_CTRL, 32'd0);
    report_test("register access");

    begin_test();
    for (int i = 0; i < 4; i++) rand_pixel(chan_val[i]);
    bus_write(REG_CTRL, 32'h1);                // rx_en
    irq0 = irq_count;
    for (int f = 0; f < 3; f++) begin
      send_frame(chan_val);
      expect_value("frame interrupts", irq_count, irq0 + f + 1);
    end
    for (int i = 0; i < 4; i++) begin
      bus_read_check(8'(REG_AVG0 + 4 * i), 32'(chan_val[i]), "channel average");
    end
    bus_read_check(REG_SIZE, {16'(NUM_ROWS), 16'(NUM_COLS)}, "frame size");
    bus_read_check(REG_FRAMES, 32'd3, "frame count");
    bus_write(REG_CTRL, 32'd0);
    send_frame(chan_val);                      // Not counted
    bus_read_check(REG_FRAMES, 32'd3, "frame count with rx off");
    expect_value("frame interrupts with rx off", irq_count, irq0 + 3);
    report_test("statistics");

    begin_test();
    for (int i = 0; i < 4; i++) rand_pixel(chan_val[i]);
    bus_write(REG_CTRL, 32'h2);                // tx_en, camera source
    pass_chk <= 1'b1;
    send_frame(chan_val);
    pass_chk <= 1'b0;
    report_test("passthrough");

    begin_test();
    bus_write(REG_CTRL, 32'h6);                // Colour bars
    check_pattern_frame(1'b0);
    bus_write(REG_CTRL, 32'h2);                // Park the generator
    bus_write(REG_CTRL, 32'hE);                // Ramp
    check_pattern_frame(1'b1);
    bus_write(REG_CTRL, 32'h2);
    report_test("test pattern");

    begin_test();
    repeat (FV_EXT + 2) @(posedge clk);
    seen0 = stretch_seen;
    send_frame(chan_val);
    expect_value("fv falls per frame", stretch_seen, seen0 + 1);
    expect_value("fv extension cycles", last_stretch, FV_EXT);
    bus_write(REG_CTRL, 32'd0);
    tx_off_chk <= 1'b1;
    send_frame(chan_val);
    tx_off_chk <= 1'b0;
    report_test("fv extension");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             errors + assert_errors);
    if (tests_failed == 0 && errors + assert_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Twenty frame times bound the whole run
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed");
    $display("Result: FAILED");
    $finish;
  end

endmodule

//--- tx_source_sel.sv
// Transmit source select
`timescale 1ns/1ps

module tx_source_sel #(
  parameter int FV_EXT = 10                    // Extra fv cycles after a frame
) (
  input  logic            pixel_clk_i,
  input  logic            rst_n_i,
  input  logic            tx_en_i,
  input  logic            pattern_sel_i,       // 1 pattern, 0 camera
  input  cam_pkg::video_t cam_i,
  input  cam_pkg::video_t pattern_i,
  output cam_pkg::video_t tx_o
);
  import cam_pkg::*;

  localparam int CNT_BITS = $clog2(FV_EXT + 2);

  video_t              sel;
  logic                fv_q;
  logic                lv_q;
  pixel_t              data_q;
  logic [CNT_BITS-1:0] ext_cnt_q;              // Cycles of stretch left

  // Source mux, blanked when transmit is off
  always_comb begin
    sel = pattern_sel_i ? pattern_i : cam_i;
    if (!tx_en_i) begin
      sel = '0;
    end
  end

  // ********************************************************************
  // Registered output with frame-valid stretch
  // ********************************************************************
  always_ff @(posedge pixel_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fv_q      <= 1'b0;
      lv_q      <= 1'b0;
      ext_cnt_q <= '0;
    end else begin
      lv_q <= sel.lv;
      fv_q <= tx_en_i & (sel.fv | (ext_cnt_q != '0));
      // Reloaded while the source is up, so each fall restarts it
      if (sel.fv) begin
        ext_cnt_q <= CNT_BITS'(FV_EXT);
      end else if (ext_cnt_q != '0) begin
        ext_cnt_q <= ext_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge pixel_clk_i) begin
    data_q <= sel.data;
  end

  assign tx_o.fv   = fv_q;
  assign tx_o.lv   = lv_q;
  assign tx_o.data = data_q;

  a_lv_in_fv : assert property (@(posedge pixel_clk_i) disable iff (!rst_n_i)
    tx_o.lv |-> tx_o.fv)
    else $error("tx_source_sel: line valid outside frame valid");

endmodule
